/* rtl/sdc_config.svh */
`ifndef SDC_CONFIG_SVH
`define SDC_CONFIG_SVH

////////////////////
// bus widths
////////////////////

`define SDC_ADDR_W          16
`define SDC_DATA_W          8

////////////////////
// sector buffer
////////////////////

`define SDC_SECTOR_BYTES    512
`define SDC_BUF_ADDR_W      9

////////////////////
// cartridge address map
////////////////////

`define SDC_SDATA_BASE      16'h7C00    // sector data window, 512 bytes
`define SDC_ENABLE_ADDR     16'h7E00    // bit 0 opens the register window
`define SDC_CMD_ADDR        16'h7E01
`define SDC_STATUS_ADDR     16'h7E02
`define SDC_SADDR_ADDR      16'h7E03    // first of four sector bytes, lsb first
`define SDC_CTYPE_ADDR      16'h7E0F
`define SDC_END_ADDR        16'h7EFF    // last byte of the register window

////////////////////
// pin scanner
////////////////////

// states per scan round of the mp pins
`define SDC_SCAN_LEN        7

`endif

/* rtl/sdc_pkg.sv */
`include "sdc_config.svh"

package sdc_pkg;

    typedef logic [`SDC_ADDR_W-1:0]     bus_addr_t;
    typedef logic [`SDC_DATA_W-1:0]     bus_data_t;
    typedef logic [`SDC_BUF_ADDR_W-1:0] buf_addr_t;
    typedef logic [31:0]                sector_t;   // sd block number

    // card type codes 0 to 3 for unknown sdv1 sdv2 sdhc
    typedef logic [1:0] card_type_t;

    // flag layout of the command byte
    typedef struct packed {
        logic       init;       // bit 7
        logic [4:0] rsvd;
        logic       wstart;     // bit 1
        logic       rstart;     // bit 0
    } sdc_cmd_flags_t;

    // command register byte seen as cpu data or as flags
    typedef union packed {
        bus_data_t      raw;
        sdc_cmd_flags_t flags;
    } sdc_cmd_u;

endpackage

/* rtl/msx_bus_sampler.sv */
`include "sdc_config.svh"

module msx_bus_sampler
    import sdc_pkg::*;
(
    input  logic       clk108_w,
    input  logic       ram_enabled_w,
    input  bus_data_t  mp,
    input  logic       rd_n,
    input  logic       wr_n,
    input  logic       sltsl_n,
    output logic [2:0] msel_n,
    output bus_addr_t  addr,
    output logic       merq_n,
    output logic       iorq_n,
    output logic       m1_n,
    output logic       rd_n_f,
    output logic       wr_n_f,
    output logic       sltsl_n_f
);

    localparam int SCAN_W = $clog2(`SDC_SCAN_LEN);
    localparam logic [SCAN_W-1:0] SCAN_LAST = SCAN_W'(`SDC_SCAN_LEN - 1);

    logic [SCAN_W-1:0] scan_st;
    logic [SCAN_W-1:0] scan_nxt;
    logic              lo_en;
    logic              hi_en;
    logic              ctl_en;
    bus_data_t         addr_lo;
    bus_data_t         addr_hi;
    logic [2:0]        strobe_meta;     // {sltsl, wr, rd}
    logic [2:0]        strobe_sync;

    // pin group driven onto mp for a scan state
    function automatic logic [2:0] phase_msel(input logic [SCAN_W-1:0] st);
        case (st)
            0, 1:    return 3'b110;     // a0..a7
            2, 3:    return 3'b101;     // a8..a15
            4, 5:    return 3'b011;     // merq iorq m1 and friends
            default: return 3'b111;     // idle slot
        endcase
    endfunction

    ////////////////////
    // scan sequencer
    ////////////////////

    assign scan_nxt = (scan_st == SCAN_LAST) ? '0 : scan_st + 1'b1;

    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            scan_st <= SCAN_LAST;       // next edge starts a round
            msel_n  <= 3'b111;
        end else begin
            scan_st <= scan_nxt;
            msel_n  <= phase_msel(scan_nxt);
        end
    end

    // mux settles in the first cycle and is sampled at the end of the second
    assign lo_en  = (scan_st == SCAN_W'(1));
    assign hi_en  = (scan_st == SCAN_W'(3));
    assign ctl_en = (scan_st == SCAN_W'(5));

    ////////////////////
    // address capture
    ////////////////////

    always_ff @(posedge clk108_w) begin
        if (lo_en)
            addr_lo <= mp;
        if (hi_en)
            addr_hi <= mp;
        if (ctl_en)
            addr <= {addr_hi, addr_lo};     // commit with the strobes below
    end

    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            merq_n <= 1'b1;
            iorq_n <= 1'b1;
            m1_n   <= 1'b1;
        end else if (ctl_en) begin
            merq_n <= mp[0];
            iorq_n <= mp[1];
            m1_n   <= mp[7];
        end
    end

    ////////////////////
    // direct strobes
    ////////////////////

    // two flops against the async cpu edge
    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            strobe_meta <= 3'b111;
            strobe_sync <= 3'b111;
        end else begin
            strobe_meta <= {sltsl_n, wr_n, rd_n};
            strobe_sync <= strobe_meta;
        end
    end

    assign rd_n_f    = strobe_sync[0];
    assign wr_n_f    = strobe_sync[1];
    assign sltsl_n_f = strobe_sync[2];

endmodule

/* rtl/sector_buffer.sv */
`include "sdc_config.svh"

module sector_buffer
    import sdc_pkg::*;
(
    input  logic      clk108_w,
    input  logic      ram_enabled_w,
    input  bus_addr_t addr,
    input  bus_data_t cd_in,
    input  logic      merq_n,
    input  logic      iorq_n,
    input  logic      m1_n,
    input  logic      rd_n_f,
    input  logic      wr_n_f,
    input  logic      sltsl_n_f,
    input  logic      sd_en,
    input  logic      sd_rstart,
    input  logic      sd_wstart,
    input  logic      sd_outen,
    input  buf_addr_t sd_outaddr,
    input  bus_data_t sd_outbyte,
    output bus_data_t sd_inbyte,
    output logic      buf_busreq,
    output bus_data_t buf_data
);

    bus_data_t sector_mem [`SDC_SECTOR_BYTES];

    logic      cpu_sel;
    logic      cpu_we;
    logic      cpu_re;
    logic      card_we;
    logic      card_re;
    buf_addr_t cpu_idx;

    ////////////////////
    // cpu window decode
    ////////////////////

    assign cpu_sel = !sltsl_n_f && !merq_n && iorq_n && m1_n && sd_en
                   && (addr >= `SDC_SDATA_BASE) && (addr < `SDC_ENABLE_ADDR);

    assign cpu_idx = addr[`SDC_BUF_ADDR_W-1:0];
    assign cpu_we  = cpu_sel && !wr_n_f;
    assign cpu_re  = cpu_sel && !rd_n_f;

    assign buf_busreq = cpu_re;

    // card side, read command fills the buffer and write command drains it
    assign card_we = sd_outen && sd_rstart;
    assign card_re = sd_outen && sd_wstart;

    ////////////////////
    // memory
    ////////////////////

    // single write port, card data has priority
    always_ff @(posedge clk108_w) begin
        if (card_we)
            sector_mem[sd_outaddr] <= sd_outbyte;
        else if (cpu_we)
            sector_mem[cpu_idx] <= cd_in;
    end

    always_ff @(posedge clk108_w) begin
        if (cpu_re)
            buf_data <= sector_mem[cpu_idx];
    end

    always_ff @(posedge clk108_w) begin
        if (card_re)
            sd_inbyte <= sector_mem[sd_outaddr];    // one cycle behind the request
    end

    // cpu must keep off the buffer while the card streams into it
    a_no_dual_write: assert property (@(posedge clk108_w) disable iff (!ram_enabled_w)
        (sd_rstart || sd_wstart) |-> !(cpu_we && card_we));

endmodule

/* rtl/sdc_registers.sv */
`include "sdc_config.svh"

module sdc_registers
    import sdc_pkg::*;
(
    input  logic       clk108_w,
    input  logic       ram_enabled_w,
    input  bus_addr_t  addr,
    input  bus_data_t  cd_in,
    input  logic       merq_n,
    input  logic       iorq_n,
    input  logic       m1_n,
    input  logic       rd_n_f,
    input  logic       wr_n_f,
    input  logic       sltsl_n_f,
    output logic       sd_en,
    output logic       sd_rstart,
    output logic       sd_wstart,
    output logic       sd_init,
    output sector_t    sd_sector,
    input  logic       sd_busy,
    input  logic       sd_done,
    input  logic       sd_crc_error,
    input  logic       sd_timeout_error,
    input  card_type_t sd_card_type,
    output logic       reg_busreq,
    output bus_data_t  reg_data
);

    logic     en_wr;
    logic     reg_sel;
    logic     reg_wr;
    sdc_cmd_u cmd_wr;

    ////////////////////
    // decode
    ////////////////////

    // enable byte is writable even while the window is closed
    assign en_wr = !sltsl_n_f && iorq_n && m1_n && !wr_n_f
                 && (addr == `SDC_ENABLE_ADDR);

    assign reg_sel = !sltsl_n_f && !merq_n && iorq_n && m1_n && sd_en
                   && (addr >= `SDC_ENABLE_ADDR) && (addr <= `SDC_END_ADDR);

    assign reg_wr     = reg_sel && !wr_n_f;
    assign reg_busreq = reg_sel && !rd_n_f;

    assign cmd_wr.raw = cd_in;

    ////////////////////
    // control registers
    ////////////////////

    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            sd_en     <= 1'b0;
            sd_rstart <= 1'b0;
            sd_wstart <= 1'b0;
            sd_init   <= 1'b0;
            sd_sector <= '0;
        end else begin
            if (en_wr)
                sd_en <= cd_in[0];

            if (sd_done) begin      // engine finished the transfer
                sd_rstart <= 1'b0;
                sd_wstart <= 1'b0;
            end

            // held cpu write repeats harmlessly
            if (reg_wr) begin
                case (addr)
                    `SDC_CMD_ADDR: begin
                        sd_rstart <= sd_rstart | cmd_wr.flags.rstart;
                        sd_wstart <= sd_wstart | cmd_wr.flags.wstart;
                        sd_init   <= sd_init   | cmd_wr.flags.init;    // sticky
                    end
                    `SDC_SADDR_ADDR:          sd_sector[7:0]   <= cd_in;
                    `SDC_SADDR_ADDR + 16'd1:  sd_sector[15:8]  <= cd_in;
                    `SDC_SADDR_ADDR + 16'd2:  sd_sector[23:16] <= cd_in;
                    `SDC_SADDR_ADDR + 16'd3:  sd_sector[31:24] <= cd_in;
                    default: ;
                endcase
            end
        end
    end

    ////////////////////
    // read mux
    ////////////////////

    always_ff @(posedge clk108_w) begin
        if (reg_busreq) begin
            case (addr)
                `SDC_ENABLE_ADDR: reg_data <= {7'b0, sd_en};
                `SDC_STATUS_ADDR: reg_data <= {sd_busy, 5'b0, sd_timeout_error, sd_crc_error};
                `SDC_CTYPE_ADDR:  reg_data <= {6'b0, sd_card_type};
                default:          reg_data <= '1;   // write-only and unused bytes
            endcase
        end
    end

    // a done pulse only answers a pending command
    a_done_needs_start: assert property (@(posedge clk108_w) disable iff (!ram_enabled_w)
        sd_done |-> (sd_rstart || sd_wstart));

endmodule

/* rtl/cart_data_port.sv */
module cart_data_port
    import sdc_pkg::*;
(
    input  logic      clk108_w,
    input  logic      ram_enabled_w,
    input  logic      sltsl_n_f,
    input  logic      rd_n_f,
    input  logic      buf_busreq,
    input  bus_data_t buf_data,
    input  logic      reg_busreq,
    input  bus_data_t reg_data,
    output bus_data_t cd_out,
    output logic      datadir
);

    ////////////////////
    // output byte
    ////////////////////

    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            cd_out <= '1;           // idle bus value
        end else begin
            if (reg_busreq)
                cd_out <= reg_data;
            else if (buf_busreq)
                cd_out <= buf_data;
        end
    end

    // low turns the pad buffer toward the cpu
    assign datadir = !(!sltsl_n_f && !rd_n_f);

    // windows of the buffer and the registers never overlap
    a_one_source: assert property (@(posedge clk108_w) disable iff (!ram_enabled_w)
        !(buf_busreq && reg_busreq));

endmodule

/* rtl/sdc_cartridge_top.sv */
module sdc_cartridge_top
    import sdc_pkg::*;
(
    input  logic       clk108_w,
    input  logic       ram_enabled_w,
    // msx slot
    input  bus_data_t  mp,
    input  logic       rd_n,
    input  logic       wr_n,
    input  logic       sltsl_n,
    output logic [2:0] msel_n,
    input  bus_data_t  cd_in,
    output bus_data_t  cd_out,
    output logic       datadir,
    // sd protocol engine
    output logic       sd_rstart,
    output logic       sd_wstart,
    output logic       sd_init,
    output sector_t    sd_sector,
    input  logic       sd_busy,
    input  logic       sd_done,
    input  logic       sd_crc_error,
    input  logic       sd_timeout_error,
    input  card_type_t sd_card_type,
    input  logic       sd_outen,
    input  buf_addr_t  sd_outaddr,
    input  bus_data_t  sd_outbyte,
    output bus_data_t  sd_inbyte
);

    bus_addr_t addr;
    logic      merq_n;
    logic      iorq_n;
    logic      m1_n;
    logic      rd_n_f;
    logic      wr_n_f;
    logic      sltsl_n_f;
    logic      sd_en;
    logic      buf_busreq;
    bus_data_t buf_data;
    logic      reg_busreq;
    bus_data_t reg_data;

    msx_bus_sampler u_sampler (
        .clk108_w, .ram_enabled_w, .mp, .rd_n, .wr_n, .sltsl_n, .msel_n,
        .addr, .merq_n, .iorq_n, .m1_n, .rd_n_f, .wr_n_f, .sltsl_n_f
    );

    sector_buffer u_buffer (
        .clk108_w, .ram_enabled_w, .addr, .cd_in, .merq_n, .iorq_n, .m1_n,
        .rd_n_f, .wr_n_f, .sltsl_n_f, .sd_en, .sd_rstart, .sd_wstart,
        .sd_outen, .sd_outaddr, .sd_outbyte, .sd_inbyte, .buf_busreq, .buf_data
    );

    sdc_registers u_regs (
        .clk108_w, .ram_enabled_w, .addr, .cd_in, .merq_n, .iorq_n, .m1_n,
        .rd_n_f, .wr_n_f, .sltsl_n_f, .sd_en, .sd_rstart, .sd_wstart, .sd_init,
        .sd_sector, .sd_busy, .sd_done, .sd_crc_error, .sd_timeout_error,
        .sd_card_type, .reg_busreq, .reg_data
    );

    cart_data_port u_data_port (
        .clk108_w, .ram_enabled_w, .sltsl_n_f, .rd_n_f, .buf_busreq, .buf_data,
        .reg_busreq, .reg_data, .cd_out, .datadir
    );

endmodule

/* dv/sdc_model.svh */
`ifndef SDC_MODEL_SVH
`define SDC_MODEL_SVH

// expected cartridge state, kept in step with every bus access
logic [7:0]  m_buf [`SDC_SECTOR_BYTES];
logic        m_en;
logic        m_rstart;
logic        m_wstart;
logic        m_init;
logic [31:0] m_sector;
logic [7:0]  m_cd_out;      // byte the data port holds

task automatic model_reset();
    m_en     = 1'b0;
    m_rstart = 1'b0;
    m_wstart = 1'b0;
    m_init   = 1'b0;
    m_sector = '0;
    m_cd_out = 8'hFF;
endtask

// readback of the register window, unused and write-only bytes give ff
function automatic logic [7:0] reg_value(input logic [15:0] a);
    case (a)
        `SDC_ENABLE_ADDR: return {7'b0, m_en};
        `SDC_STATUS_ADDR: return {sd_busy, 5'b0, sd_timeout_error, sd_crc_error};
        `SDC_CTYPE_ADDR:  return {6'b0, sd_card_type};
        default:          return 8'hFF;
    endcase
endfunction

// ctl as on the pins, merq_n bit 0, iorq_n bit 1, m1_n bit 7
task automatic model_access(input logic [15:0] a, input logic [7:0] ctl, input logic slot_n,
                            input logic is_wr, input logic [7:0] d,
                            output logic [7:0] exp_out);
    logic mem_sel;
    logic in_buf;
    logic in_reg;
    mem_sel = !slot_n && !ctl[0] && ctl[1] && ctl[7] && m_en;
    in_buf  = (a >= `SDC_SDATA_BASE) && (a < `SDC_ENABLE_ADDR);
    in_reg  = (a >= `SDC_ENABLE_ADDR) && (a <= `SDC_END_ADDR);
    if (is_wr) begin
        if (mem_sel && in_buf)
            m_buf[a[`SDC_BUF_ADDR_W-1:0]] = d;
        if (mem_sel && a == `SDC_CMD_ADDR) begin
            m_rstart |= d[0];
            m_wstart |= d[1];
            m_init   |= d[7];       // sticky until reset
        end
        if (mem_sel && a >= `SDC_SADDR_ADDR && a < `SDC_SADDR_ADDR + 4)
            m_sector[8*(a - `SDC_SADDR_ADDR) +: 8] = d;     // lsb first
        // enable byte needs neither merq nor an open window
        if (!slot_n && ctl[1] && ctl[7] && a == `SDC_ENABLE_ADDR)
            m_en = d[0];
    end else if (mem_sel && in_buf) begin
        m_cd_out = m_buf[a[`SDC_BUF_ADDR_W-1:0]];
    end else if (mem_sel && in_reg) begin
        m_cd_out = reg_value(a);
    end
    exp_out = m_cd_out;
endtask

`endif

/* dv/sdc_tb.sv */
`include "sdc_config.svh"

module sdc_tb;

    localparam logic [7:0] MEM_CTL = 8'hFE;    // merq low, iorq and m1 high
    localparam logic [7:0] IO_CTL  = 8'hFC;
    localparam logic [7:0] M1_CTL  = 8'h7E;
    localparam logic [2:0] SCAN_SEQ [7] = '{3'b110, 3'b110, 3'b101, 3'b101,
                                            3'b011, 3'b011, 3'b111};

    logic        clk108_w;
    logic        ram_enabled_w;
    logic [7:0]  mp = 8'hFF;
    logic        rd_n;
    logic        wr_n;
    logic        sltsl_n;
    logic [2:0]  msel_n;
    logic [7:0]  cd_in;
    logic [7:0]  cd_out;
    logic        datadir;
    logic        sd_rstart;
    logic        sd_wstart;
    logic        sd_init;
    logic [31:0] sd_sector;
    logic        sd_busy;
    logic        sd_done;
    logic        sd_crc_error;
    logic        sd_timeout_error;
    logic [1:0]  sd_card_type;
    logic        sd_outen;
    logic [8:0]  sd_outaddr;
    logic [7:0]  sd_outbyte;
    logic [7:0]  sd_inbyte;
    logic [15:0] cpu_addr;      // cpu side of the pin mux
    logic [7:0]  cpu_ctl;

    `include "sdc_model.svh"

    sdc_cartridge_top dut0 (.*);

    initial begin
        clk108_w = 1'b0;
        forever #10 clk108_w = ~clk108_w;
    end

    // board multiplexer, one pin group per msel_n value
    always @(posedge clk108_w) begin
        case (msel_n)
            3'b110:  mp <= cpu_addr[7:0];
            3'b101:  mp <= cpu_addr[15:8];
            3'b011:  mp <= cpu_ctl;
            default: mp <= 8'hFF;
        endcase
    end

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            $display("Error: %s expected %0h actual %0h", name, exp, act);
            $display("Testbench failed");
            $fatal(1);
        end
    endtask

    task automatic check_outputs(input string name);
        @(negedge clk108_w);
        check_value({name, " sd_rstart"}, m_rstart, sd_rstart);
        check_value({name, " sd_wstart"}, m_wstart, sd_wstart);
        check_value({name, " sd_init"}, m_init, sd_init);
        check_value({name, " sd_sector"}, m_sector, sd_sector);
    endtask

    // address settles with the slot idle, then strobes hold for 24 cycles
    task automatic bus_access(input logic [15:0] a, input logic [7:0] ctl, input logic slot_n,
                              input logic is_wr, input logic [7:0] d, input string name);
        logic [7:0] exp_out;
        @(posedge clk108_w);
        cpu_addr <= a;
        cpu_ctl  <= ctl;
        repeat (16) @(posedge clk108_w);
        sltsl_n <= slot_n;
        cd_in   <= d;
        wr_n    <= !is_wr;
        rd_n    <= is_wr;
        model_access(a, ctl, slot_n, is_wr, d, exp_out);
        repeat (23) @(posedge clk108_w);
        @(negedge clk108_w);
        check_value({name, " cd_out"}, exp_out, cd_out);
        check_value({name, " datadir"}, !(!slot_n && !is_wr), datadir);
        @(posedge clk108_w);
        rd_n    <= 1'b1;
        wr_n    <= 1'b1;
        sltsl_n <= 1'b1;
        repeat (4) @(posedge clk108_w);
        check_outputs(name);
    endtask

    task automatic pulse_done();
        @(posedge clk108_w);
        sd_done <= 1'b1;
        @(posedge clk108_w);
        sd_done  <= 1'b0;
        m_rstart = 1'b0;
        m_wstart = 1'b0;
        check_outputs("done pulse");
    endtask

    initial begin : main_seq
        logic [15:0] a;
        logic [7:0]  d;
        logic [8:0]  idx;
        logic [15:0] off_list [$];
        void'($urandom(21694));
        ram_enabled_w = 1'b0;
        {rd_n, wr_n, sltsl_n} = 3'b111;
        {sd_busy, sd_done, sd_crc_error, sd_timeout_error, sd_outen} = '0;
        {sd_card_type, sd_outaddr, sd_outbyte, cd_in} = '0;
        cpu_addr = 16'h0000;
        cpu_ctl  = 8'hFF;
        model_reset();
        repeat (4) @(posedge clk108_w);
        ram_enabled_w <= 1'b1;
        @(negedge clk108_w);
        check_value("reset datadir", 1'b1, datadir);
        check_value("reset cd_out", 8'hFF, cd_out);
        for (int i = 0; i < 14; i++) begin
            @(posedge clk108_w);
            @(negedge clk108_w);
            check_value("scan msel_n", SCAN_SEQ[i % 7], msel_n);
        end

        ////////////////////
        // enable and command flags
        ////////////////////
        bus_access(`SDC_ENABLE_ADDR, MEM_CTL, 1'b0, 1'b1, 8'h01, "enable write");
        bus_access(`SDC_ENABLE_ADDR, MEM_CTL, 1'b0, 1'b0, 8'h00, "enable read");
        for (int i = 0; i < 6; i++) begin
            bus_access(`SDC_CMD_ADDR, MEM_CTL, 1'b0, 1'b1, 8'($urandom), "command write");
            if (i % 2 == 1 && (m_rstart || m_wstart))
                pulse_done();
        end
        if (m_rstart || m_wstart)
            pulse_done();

        ////////////////////
        // card streams a sector in, then reads bytes back out
        ////////////////////
        bus_access(`SDC_CMD_ADDR, MEM_CTL, 1'b0, 1'b1, 8'h01, "read command");
        for (int i = 0; i < `SDC_SECTOR_BYTES; i++) begin
            d = 8'($urandom);
            @(posedge clk108_w);
            sd_outen   <= 1'b1;
            sd_outaddr <= 9'(i);
            sd_outbyte <= d;
            m_buf[i] = d;
        end
        @(posedge clk108_w);
        sd_outen <= 1'b0;
        for (int i = 0; i < 12; i++) begin
            a = 16'(`SDC_SDATA_BASE + $urandom % `SDC_SECTOR_BYTES);
            bus_access(a, MEM_CTL, 1'b0, 1'b0, 8'h00, "card data read");
        end
        pulse_done();
        bus_access(`SDC_CMD_ADDR, MEM_CTL, 1'b0, 1'b1, 8'h02, "write command");
        for (int i = 0; i < 16; i++) begin
            idx = 9'($urandom);
            @(posedge clk108_w);
            sd_outen   <= 1'b1;
            sd_outaddr <= idx;
            @(posedge clk108_w);
            sd_outen <= 1'b0;
            @(negedge clk108_w);
            check_value("card write byte", m_buf[idx], sd_inbyte);
        end
        pulse_done();

        ////////////////////
        // cpu traffic on the buffer
        ////////////////////
        for (int i = 0; i < 24; i++) begin
            a = 16'(`SDC_SDATA_BASE + $urandom % `SDC_SECTOR_BYTES);
            bus_access(a, MEM_CTL, 1'b0, 1'($urandom), 8'($urandom), "buffer access");
        end
        bus_access(`SDC_ENABLE_ADDR, MEM_CTL, 1'b0, 1'b1, 8'h00, "disable");
        for (int i = 0; i < 6; i++) begin
            a = 16'(`SDC_SDATA_BASE + $urandom % `SDC_SECTOR_BYTES);
            off_list.push_back(a);
            bus_access(a, MEM_CTL, 1'b0, 1'b1, 8'($urandom), "disabled write");
        end
        bus_access(`SDC_ENABLE_ADDR, MEM_CTL, 1'b0, 1'b1, 8'h01, "enable again");
        foreach (off_list[i])
            bus_access(off_list[i], MEM_CTL, 1'b0, 1'b0, 8'h00, "disabled readback");

        // status inputs, card type and the sector number
        for (int i = 0; i < 3; i++) begin
            @(posedge clk108_w);
            sd_busy          <= 1'($urandom);
            sd_crc_error     <= 1'($urandom);
            sd_timeout_error <= 1'($urandom);
            sd_card_type     <= 2'($urandom);
            bus_access(`SDC_STATUS_ADDR, MEM_CTL, 1'b0, 1'b0, 8'h00, "status read");
            bus_access(`SDC_CTYPE_ADDR, MEM_CTL, 1'b0, 1'b0, 8'h00, "card type read");
        end
        for (int i = 0; i < 4; i++)
            bus_access(16'(`SDC_SADDR_ADDR + i), MEM_CTL, 1'b0, 1'b1, 8'($urandom), "sector");
        for (int i = 0; i < 8; i++) begin
            a = 16'(`SDC_ENABLE_ADDR + $urandom % 256);
            bus_access(a, MEM_CTL, 1'b0, 1'b0, 8'h00, "register read");
        end

        ////////////////////
        // accesses the cartridge must ignore
        ////////////////////
        for (int i = 0; i < 12; i++) begin
            a = 16'(`SDC_SDATA_BASE + $urandom % 16'h300);
            case ($urandom % 3)
                0: bus_access(a, MEM_CTL, 1'b1, 1'($urandom), 8'($urandom), "slot idle");
                1: bus_access(a, IO_CTL, 1'b0, 1'($urandom), 8'($urandom), "io cycle");
                default: bus_access(a, M1_CTL, 1'b0, 1'($urandom), 8'($urandom), "m1 cycle");
            endcase
            bus_access(a, MEM_CTL, 1'b0, 1'b0, 8'h00, "ignored readback");
        end

        $display("Testbench passed");
        $finish;
    end

endmodule

/* all.f */
+incdir+rtl
+incdir+dv
rtl/sdc_pkg.sv
rtl/msx_bus_sampler.sv
rtl/sector_buffer.sv
rtl/sdc_registers.sv
rtl/cart_data_port.sv
rtl/sdc_cartridge_top.sv
dv/sdc_tb.sv
